//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_ahb_fir
FILELIST  ?= ahb_fir.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '** PASS **'

clean:
	rm -rf $(BUILD_DIR)

//--- ahb_fir.f
logic/ahb_pkg.sv
logic/fir_pkg.sv
logic/ahb_fir_regs.sv
logic/fir_controller.sv
logic/fir_datapath.sv
logic/ahb_fir_top.sv
verification/tb_ahb_fir.sv

//--- logic/ahb_fir_regs.sv
`timescale 1ns/1ps
`default_nettype none

module ahb_fir_regs (
    input  wire                          clk,
    input  wire                          n_rst,
    input  wire                          hsel,
    input  wire [3:0]                    haddr,
    input  wire ahb_pkg::htrans_t        htrans,
    input  wire ahb_pkg::hsize_t         hsize,
    input  wire                          hwrite,
    input  wire [fir_pkg::DATA_W-1:0]    hwdata,
    input  wire [fir_pkg::TAP_W-1:0]     coefficient_num,
    input  wire                          load_coeff,
    input  wire                          modwait,
    input  wire                          err,
    input  wire [fir_pkg::DATA_W-1:0]    fir_out,
    output logic [fir_pkg::DATA_W-1:0]   hrdata,
    output logic                         hresp,
    output logic [fir_pkg::DATA_W-1:0]   sample_data,
    output logic                         data_ready,
    output logic                         new_coefficient_set,
    output logic [fir_pkg::DATA_W-1:0]   fir_coefficient
);

    import ahb_pkg::*;
    import fir_pkg::*;

    logic [DATA_W-1:0] coef_table [NUM_TAPS];

    logic              accept;
    logic              bad_access;
    reg_addr_t         addr_even;

    // data phase copy of the accepted address phase
    logic              dp_valid;
    logic              dp_write;
    logic              dp_odd;
    reg_addr_t         dp_reg;
    hsize_t            dp_size;

    logic              wr_en;
    logic              lo_en;
    logic              hi_en;
    logic [TAP_W-1:0]  dp_idx;
    logic [DATA_W-1:0] rd_word;

    assign accept    = hsel && (htrans == NONSEQ || htrans == SEQ);
    assign addr_even = reg_addr_t'({haddr[3:1], 1'b0});

    always_comb begin
        bad_access = 1'b0;
        if (hsize != BYTE && hsize != HALF) begin
            bad_access = 1'b1;
        end else if (hsize == HALF && haddr[0]) begin
            bad_access = 1'b1;
        end else if (hwrite && (addr_even == ADDR_STATUS || addr_even == ADDR_RESULT)) begin
            bad_access = 1'b1;
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            dp_valid <= 1'b0;
            dp_write <= 1'b0;
            dp_odd   <= 1'b0;
            dp_reg   <= ADDR_STATUS;
            dp_size  <= BYTE;
            hresp    <= 1'b0;
        end else begin
            dp_valid <= accept && !bad_access;
            hresp    <= accept && bad_access;
            if (accept) begin
                dp_write <= hwrite;
                dp_odd   <= haddr[0];
                dp_reg   <= addr_even;
                dp_size  <= hsize;
            end
        end
    end

    // lane selection, halfword uses both
    assign wr_en  = dp_valid && dp_write;
    assign lo_en  = (dp_size == HALF) || !dp_odd;
    assign hi_en  = (dp_size == HALF) || dp_odd;
    assign dp_idx = TAP_W'((dp_reg - ADDR_COEF0) >> 1);

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            sample_data         <= '0;
            data_ready          <= 1'b0;
            new_coefficient_set <= 1'b0;
            for (int i = 0; i < NUM_TAPS; i++) begin
                coef_table[i] <= '0;
            end
        end else begin
            // high byte completes a sample
            data_ready <= wr_en && dp_reg == ADDR_SAMPLE && hi_en;
            if (load_coeff && coefficient_num == TAP_W'(NUM_TAPS - 1)) begin
                new_coefficient_set <= 1'b0;
            end
            if (wr_en) begin
                case (dp_reg)
                    ADDR_SAMPLE: begin
                        if (lo_en) begin
                            sample_data[7:0] <= hwdata[7:0];
                        end
                        if (hi_en) begin
                            sample_data[15:8] <= hwdata[15:8];
                        end
                    end
                    ADDR_COEF0, ADDR_COEF1, ADDR_COEF2, ADDR_COEF3: begin
                        if (lo_en) begin
                            coef_table[dp_idx][7:0] <= hwdata[7:0];
                        end
                        if (hi_en) begin
                            coef_table[dp_idx][15:8] <= hwdata[15:8];
                        end
                    end
                    ADDR_LOAD: begin
                        if (lo_en && hwdata[0]) begin
                            new_coefficient_set <= 1'b1;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        rd_word = '0;
        case (dp_reg)
            ADDR_STATUS: begin
                rd_word[STATUS_BUSY_BIT] = modwait || new_coefficient_set;
                rd_word[STATUS_ERR_BIT]  = err;
            end
            ADDR_RESULT: rd_word = fir_out;
            ADDR_SAMPLE: rd_word = sample_data;
            ADDR_COEF0, ADDR_COEF1, ADDR_COEF2, ADDR_COEF3: rd_word = coef_table[dp_idx];
            ADDR_LOAD:   rd_word[0] = new_coefficient_set;
            default:     rd_word = '0;
        endcase
    end

    // byte reads keep their lane, rest zero
    always_comb begin
        hrdata = '0;
        if (dp_valid && !dp_write) begin
            if (dp_size == HALF) begin
                hrdata = rd_word;
            end else if (dp_odd) begin
                hrdata[15:8] = rd_word[15:8];
            end else begin
                hrdata[7:0] = rd_word[7:0];
            end
        end
    end

    assign fir_coefficient = coef_table[coefficient_num];

endmodule

`default_nettype wire

//--- logic/ahb_fir_top.sv
`timescale 1ns/1ps
`default_nettype none

module ahb_fir_top (
    input  wire                          clk,
    input  wire                          n_rst,
    input  wire                          hsel,
    input  wire [3:0]                    haddr,
    input  wire ahb_pkg::htrans_t        htrans,
    input  wire ahb_pkg::hsize_t         hsize,
    input  wire                          hwrite,
    input  wire [fir_pkg::DATA_W-1:0]    hwdata,
    output wire [fir_pkg::DATA_W-1:0]    hrdata,
    output wire                          hresp
);

    import fir_pkg::*;

    wire [DATA_W-1:0] sample_data;
    wire [DATA_W-1:0] fir_coefficient;
    wire [DATA_W-1:0] fir_out;
    wire [TAP_W-1:0]  coefficient_num;
    wire [TAP_W-1:0]  tap;
    wire              data_ready;
    wire              new_coefficient_set;
    wire              load_coeff;
    wire              shift_sample;
    wire              mac_en;
    wire              result_latch;
    wire              modwait;
    wire              err;
    wire              saturated;

    ahb_fir_regs u_regs (
        .clk                 (clk),
        .n_rst               (n_rst),
        .hsel                (hsel),
        .haddr               (haddr),
        .htrans              (htrans),
        .hsize               (hsize),
        .hwrite              (hwrite),
        .hwdata              (hwdata),
        .coefficient_num     (coefficient_num),
        .load_coeff          (load_coeff),
        .modwait             (modwait),
        .err                 (err),
        .fir_out             (fir_out),
        .hrdata              (hrdata),
        .hresp               (hresp),
        .sample_data         (sample_data),
        .data_ready          (data_ready),
        .new_coefficient_set (new_coefficient_set),
        .fir_coefficient     (fir_coefficient)
    );

    fir_controller u_ctrl (
        .clk                 (clk),
        .n_rst               (n_rst),
        .data_ready          (data_ready),
        .new_coefficient_set (new_coefficient_set),
        .saturated           (saturated),
        .load_coeff          (load_coeff),
        .coefficient_num     (coefficient_num),
        .shift_sample        (shift_sample),
        .mac_en              (mac_en),
        .tap                 (tap),
        .result_latch        (result_latch),
        .modwait             (modwait),
        .err                 (err)
    );

    fir_datapath u_dp (
        .clk                 (clk),
        .n_rst               (n_rst),
        .sample_data         (sample_data),
        .fir_coefficient     (fir_coefficient),
        .load_coeff          (load_coeff),
        .coefficient_num     (coefficient_num),
        .shift_sample        (shift_sample),
        .mac_en              (mac_en),
        .tap                 (tap),
        .result_latch        (result_latch),
        .fir_out             (fir_out),
        .saturated           (saturated)
    );

endmodule

`default_nettype wire

//--- logic/ahb_pkg.sv
`default_nettype none

package ahb_pkg;

    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_t;

    typedef enum logic [2:0] {
        BYTE = 3'b000,
        HALF = 3'b001,
        WORD = 3'b010
    } hsize_t;

    // byte addresses of the register map
    typedef enum logic [3:0] {
        ADDR_STATUS = 4'd0,
        ADDR_RESULT = 4'd2,
        ADDR_SAMPLE = 4'd4,
        ADDR_COEF0  = 4'd6,
        ADDR_COEF1  = 4'd8,
        ADDR_COEF2  = 4'd10,
        ADDR_COEF3  = 4'd12,
        ADDR_LOAD   = 4'd14
    } reg_addr_t;

    localparam int STATUS_BUSY_BIT = 0;
    localparam int STATUS_ERR_BIT  = 8;

endpackage

`default_nettype wire

//--- logic/fir_controller.sv
`timescale 1ns/1ps
`default_nettype none

module fir_controller (
    input  wire                         clk,
    input  wire                         n_rst,
    input  wire                         data_ready,
    input  wire                         new_coefficient_set,
    input  wire                         saturated,
    output logic                        load_coeff,
    output logic [fir_pkg::TAP_W-1:0]   coefficient_num,
    output logic                        shift_sample,
    output logic                        mac_en,
    output logic [fir_pkg::TAP_W-1:0]   tap,
    output logic                        result_latch,
    output logic                        modwait,
    output logic                        err
);

    import fir_pkg::*;

    fir_state_t       state;
    fir_state_t       next_state;
    logic [TAP_W-1:0] cnt;
    logic [TAP_W-1:0] next_cnt;
    logic             pending;
    logic             next_pending;
    logic             next_err;
    logic             last_tap;

    assign last_tap = cnt == TAP_W'(NUM_TAPS - 1);

    always_comb begin
        next_state   = state;
        next_cnt     = cnt;
        next_pending = pending;
        next_err     = err;
        case (state)
            S_IDLE: begin
                // coefficient load wins, sample waits as pending
                if (new_coefficient_set) begin
                    next_state = S_LOAD;
                    next_cnt   = '0;
                    if (data_ready) begin
                        next_pending = 1'b1;
                    end
                end else if (data_ready || pending) begin
                    next_state   = S_SHIFT;
                    next_pending = 1'b0;
                    next_err     = 1'b0;
                end
            end
            S_LOAD: begin
                if (data_ready) begin
                    next_pending = 1'b1;
                end
                next_cnt = cnt + 1'b1;
                if (last_tap) begin
                    next_state = S_IDLE;
                end
            end
            S_SHIFT: begin
                next_cnt   = '0;
                next_state = S_MAC;
            end
            S_MAC: begin
                next_cnt = cnt + 1'b1;
                if (last_tap) begin
                    next_state = S_DONE;
                end
            end
            S_DONE: begin
                next_state = S_IDLE;
                if (saturated) begin
                    next_err = 1'b1;
                end
            end
            default: next_state = S_IDLE;
        endcase
        // overrun, sample is dropped
        if (modwait && data_ready) begin
            next_err = 1'b1;
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state   <= S_IDLE;
            cnt     <= '0;
            pending <= 1'b0;
            err     <= 1'b0;
        end else begin
            state   <= next_state;
            cnt     <= next_cnt;
            pending <= next_pending;
            err     <= next_err;
        end
    end

    assign load_coeff      = state == S_LOAD;
    assign coefficient_num = cnt;
    assign shift_sample    = state == S_SHIFT;
    assign mac_en          = state == S_MAC;
    assign tap             = cnt;
    assign result_latch    = state == S_DONE;
    assign modwait         = state == S_SHIFT || state == S_MAC || state == S_DONE;

endmodule

`default_nettype wire

//--- logic/fir_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module fir_datapath (
    input  wire                          clk,
    input  wire                          n_rst,
    input  wire [fir_pkg::DATA_W-1:0]    sample_data,
    input  wire [fir_pkg::DATA_W-1:0]    fir_coefficient,
    input  wire                          load_coeff,
    input  wire [fir_pkg::TAP_W-1:0]     coefficient_num,
    input  wire                          shift_sample,
    input  wire                          mac_en,
    input  wire [fir_pkg::TAP_W-1:0]     tap,
    input  wire                          result_latch,
    output logic [fir_pkg::DATA_W-1:0]   fir_out,
    output logic                         saturated
);

    import fir_pkg::*;

    // entry 0 holds the newest sample
    logic signed [DATA_W-1:0]   samples [NUM_TAPS];
    logic signed [DATA_W-1:0]   coefs [NUM_TAPS];
    logic signed [ACC_W-1:0]    acc;
    logic signed [2*DATA_W-1:0] product;
    logic signed [ACC_W-1:0]    scaled;
    logic signed [DATA_W-1:0]   clamped;

    assign product = samples[tap] * coefs[tap];

    // back to Q1.15, truncating
    assign scaled = acc >>> FRAC_BITS;

    always_comb begin
        saturated = 1'b0;
        clamped   = scaled[DATA_W-1:0];
        if (scaled > SAT_MAX) begin
            clamped   = SAT_MAX;
            saturated = 1'b1;
        end else if (scaled < SAT_MIN) begin
            clamped   = SAT_MIN;
            saturated = 1'b1;
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            for (int i = 0; i < NUM_TAPS; i++) begin
                samples[i] <= '0;
                coefs[i]   <= '0;
            end
            acc     <= '0;
            fir_out <= '0;
        end else begin
            if (shift_sample) begin
                samples[0] <= sample_data;
                for (int i = 1; i < NUM_TAPS; i++) begin
                    samples[i] <= samples[i-1];
                end
                acc <= '0;
            end
            if (mac_en) begin
                acc <= acc + ACC_W'(product);
            end
            if (load_coeff) begin
                coefs[coefficient_num] <= fir_coefficient;
            end
            if (result_latch) begin
                fir_out <= clamped;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/fir_pkg.sv
`default_nettype none

package fir_pkg;

    localparam int DATA_W    = 16;
    localparam int NUM_TAPS  = 4;
    localparam int TAP_W     = 2;
    localparam int ACC_W     = 34;
    // coefficients are Q1.15
    localparam int FRAC_BITS = 15;

    localparam logic signed [DATA_W-1:0] SAT_MAX = 16'sh7fff;
    localparam logic signed [DATA_W-1:0] SAT_MIN = 16'sh8000;

    typedef enum logic [2:0] {
        S_IDLE  = 3'd0,
        S_LOAD  = 3'd1,
        S_SHIFT = 3'd2,
        S_MAC   = 3'd3,
        S_DONE  = 3'd4
    } fir_state_t;

endpackage

`default_nettype wire

//--- verification/tb_ahb_fir.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ahb_fir;

    import ahb_pkg::*;
    import fir_pkg::*;

    localparam int IDLE_TIMEOUT  = 50;
    localparam int DRAIN_TIMEOUT = 20;

    logic        clk;
    logic        n_rst;
    logic        hsel;
    logic [3:0]  haddr;
    htrans_t     htrans;
    hsize_t      hsize;
    logic        hwrite;
    logic [15:0] hwdata;
    wire  [15:0] hrdata;
    wire         hresp;

    logic [15:0] rd;
    logic        resp;
    logic [31:0] rng_state;
    // entry 0 (newest) in bits 15:0
    logic [63:0] model_line;
    logic [63:0] model_coef;
    logic [63:0] rand_coef;
    int          polls;

    string       name_q[$];
    logic [15:0] exp_q[$];
    logic [15:0] act_q[$];

    ahb_fir_top DUT (
        .clk    (clk),
        .n_rst  (n_rst),
        .hsel   (hsel),
        .haddr  (haddr),
        .htrans (htrans),
        .hsize  (hsize),
        .hwrite (hwrite),
        .hwdata (hwdata),
        .hrdata (hrdata),
        .hresp  (hresp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lcg(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Q1.15 sum of products with floor shift and clamp to 16 bits
    function automatic logic [15:0] fir_ref(input logic [63:0] line, input logic [63:0] coef,
                                            output logic sat);
        longint sum;
        longint scaled;
        sum = 0;
        for (int i = 0; i < 4; i++) begin
            sum += longint'($signed(line[16*i +: 16])) * longint'($signed(coef[16*i +: 16]));
        end
        scaled = sum >>> 15;
        sat = 1'b0;
        if (scaled > 32767) begin
            sat = 1'b1;
            return 16'h7fff;
        end
        if (scaled < -32768) begin
            sat = 1'b1;
            return 16'h8000;
        end
        return 16'(scaled);
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        if (actual !== expected) begin
            report_failure($sformatf("MISMATCH %s: expected %h, actual %h",
                                     name, expected, actual));
        end
    endtask

    task automatic post_result(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        name_q.push_back(name);
        exp_q.push_back(expected);
        act_q.push_back(actual);
    endtask

    // address phase followed by data phase, falling edge to falling edge
    task automatic ahb_write(input logic [3:0] addr, input hsize_t size,
                             input logic [15:0] data, output logic err_resp);
        hsel   = 1'b1;
        htrans = NONSEQ;
        haddr  = addr;
        hsize  = size;
        hwrite = 1'b1;
        @(negedge clk);
        err_resp = hresp;
        hsel     = 1'b0;
        htrans   = IDLE;
        hwdata   = data;
        @(negedge clk);
    endtask

    task automatic ahb_read(input logic [3:0] addr, input hsize_t size,
                            output logic [15:0] data, output logic err_resp);
        hsel   = 1'b1;
        htrans = NONSEQ;
        haddr  = addr;
        hsize  = size;
        hwrite = 1'b0;
        @(negedge clk);
        err_resp = hresp;
        data     = hrdata;
        hsel     = 1'b0;
        htrans   = IDLE;
        @(negedge clk);
    endtask

    task automatic wait_idle();
        logic [15:0] status;
        logic        err_resp;
        int          count;
        count = 0;
        ahb_read(ADDR_STATUS, HALF, status, err_resp);
        while (status[0]) begin
            count++;
            if (count > IDLE_TIMEOUT) begin
                report_failure("timeout: busy flag never cleared");
            end
            ahb_read(ADDR_STATUS, HALF, status, err_resp);
        end
    endtask

    task automatic load_coefs(input logic [63:0] coef);
        logic err_resp;
        for (int i = 0; i < 4; i++) begin
            ahb_write(4'(6 + 2 * i), HALF, coef[16*i +: 16], err_resp);
            check_value("coef write resp", 16'h0000, {15'b0, err_resp});
        end
        ahb_write(ADDR_LOAD, HALF, 16'h0001, err_resp);
        wait_idle();
        model_coef = coef;
    endtask

    task automatic filter_sample(input logic [15:0] s, input logic by_bytes, input string name);
        logic [15:0] exp_res;
        logic [15:0] data;
        logic        sat;
        logic        err_resp;
        if (by_bytes) begin
            // junk in the unused lane and the high byte last
            ahb_write(4'd4, BYTE, {~s[15:8], s[7:0]}, err_resp);
            check_value({name, " low byte resp"}, 16'h0000, {15'b0, err_resp});
            ahb_write(4'd5, BYTE, {s[15:8], ~s[7:0]}, err_resp);
        end else begin
            ahb_write(ADDR_SAMPLE, HALF, s, err_resp);
        end
        check_value({name, " write resp"}, 16'h0000, {15'b0, err_resp});
        wait_idle();
        model_line = {model_line[47:0], s};
        exp_res = fir_ref(model_line, model_coef, sat);
        ahb_read(ADDR_RESULT, HALF, data, err_resp);
        post_result({name, " result"}, exp_res, data);
        ahb_read(ADDR_STATUS, HALF, data, err_resp);
        post_result({name, " status"}, sat ? 16'h0100 : 16'h0000, data);
    endtask

    initial begin : compare_results
        string       name;
        logic [15:0] expected;
        logic [15:0] actual;
        forever begin
            @(posedge clk);
            while (exp_q.size() != 0) begin
                name     = name_q.pop_front();
                expected = exp_q.pop_front();
                actual   = act_q.pop_front();
                check_value(name, expected, actual);
            end
        end
    end

    initial begin
        n_rst      = 1'b0;
        hsel       = 1'b0;
        haddr      = 4'd0;
        htrans     = IDLE;
        hsize      = BYTE;
        hwrite     = 1'b0;
        hwdata     = 16'h0000;
        rng_state  = 32'h2755_f6d7;
        model_line = '0;
        model_coef = '0;
        repeat (8) @(negedge clk);
        n_rst = 1'b1;
        @(negedge clk);

        // reset values and lane placement
        for (int a = 0; a < 16; a += 2) begin
            ahb_read(4'(a), HALF, rd, resp);
            check_value($sformatf("reset read %0d", a), 16'h0000, rd);
            check_value($sformatf("reset resp %0d", a), 16'h0000, {15'b0, resp});
        end
        ahb_write(ADDR_COEF0, HALF, 16'h1234, resp);
        ahb_read(ADDR_COEF0, HALF, rd, resp);
        check_value("coef0 half", 16'h1234, rd);
        ahb_read(4'd6, BYTE, rd, resp);
        check_value("coef0 low byte", 16'h0034, rd);
        ahb_read(4'd7, BYTE, rd, resp);
        check_value("coef0 high byte", 16'h1200, rd);
        ahb_write(4'd9, BYTE, 16'hab77, resp);
        ahb_read(ADDR_COEF1, HALF, rd, resp);
        check_value("coef1 high lane", 16'hab00, rd);
        ahb_write(4'd8, BYTE, 16'h55cd, resp);
        ahb_read(ADDR_COEF1, HALF, rd, resp);
        check_value("coef1 both lanes", 16'habcd, rd);
        ahb_write(4'd4, BYTE, 16'hee3c, resp);
        ahb_read(ADDR_SAMPLE, HALF, rd, resp);
        check_value("sample low lane", 16'h003c, rd);
        filter_sample(16'h8001, 1'b0, "first sample");
        ahb_read(4'd4, BYTE, rd, resp);
        check_value("sample low byte", 16'h0001, rd);
        ahb_read(4'd5, BYTE, rd, resp);
        check_value("sample high byte", 16'h8000, rd);

        // error responses leave registers alone
        ahb_write(ADDR_STATUS, HALF, 16'hffff, resp);
        check_value("status write resp", 16'h0001, {15'b0, resp});
        ahb_read(ADDR_STATUS, HALF, rd, resp);
        check_value("status after bad write", 16'h0000, rd);
        ahb_write(ADDR_RESULT, HALF, 16'hffff, resp);
        check_value("result write resp", 16'h0001, {15'b0, resp});
        ahb_read(ADDR_RESULT, HALF, rd, resp);
        check_value("result after bad write", 16'h0000, rd);
        ahb_write(ADDR_COEF2, WORD, 16'hffff, resp);
        check_value("word write resp", 16'h0001, {15'b0, resp});
        ahb_write(4'd11, HALF, 16'hffff, resp);
        check_value("odd half resp", 16'h0001, {15'b0, resp});
        ahb_read(ADDR_COEF2, HALF, rd, resp);
        check_value("coef2 after bad writes", 16'h0000, rd);

        // coefficient load holds the flag and busy until done
        for (int i = 0; i < 4; i++) begin
            ahb_write(4'(6 + 2 * i), HALF, 16'h1000 * 16'(i + 1), resp);
        end
        ahb_write(ADDR_LOAD, HALF, 16'h0001, resp);
        ahb_read(ADDR_LOAD, HALF, rd, resp);
        check_value("load flag set", 16'h0001, rd);
        ahb_read(ADDR_STATUS, HALF, rd, resp);
        check_value("busy during load", 16'h0001, rd);
        wait_idle();
        ahb_read(ADDR_LOAD, HALF, rd, resp);
        check_value("load flag cleared", 16'h0000, rd);
        model_coef = {16'h4000, 16'h3000, 16'h2000, 16'h1000};
        filter_sample(16'h4000, 1'b0, "fixed coef sample");

        // random coefficients and samples
        for (int i = 0; i < 4; i++) begin
            rng_state = lcg(rng_state);
            rand_coef[16*i +: 16] = rng_state[31:16];
        end
        load_coefs(rand_coef);
        for (int i = 0; i < 20; i++) begin
            rng_state = lcg(rng_state);
            filter_sample(rng_state[31:16], rng_state[15], $sformatf("sample %0d", i));
        end

        // saturation at both limits
        load_coefs({4{16'h7fff}});
        for (int i = 0; i < 4; i++) begin
            filter_sample(16'h7fff, 1'b0, $sformatf("high sat %0d", i));
        end
        ahb_read(ADDR_RESULT, HALF, rd, resp);
        check_value("positive limit", 16'h7fff, rd);
        for (int i = 0; i < 4; i++) begin
            filter_sample(16'h8000, 1'b1, $sformatf("low sat %0d", i));
        end
        ahb_read(ADDR_RESULT, HALF, rd, resp);
        check_value("negative limit", 16'h8000, rd);

        // overrun drops the second sample
        load_coefs({4{16'h0800}});
        ahb_write(ADDR_SAMPLE, HALF, 16'h1234, resp);
        check_value("overrun first resp", 16'h0000, {15'b0, resp});
        ahb_write(ADDR_SAMPLE, HALF, 16'h4321, resp);
        check_value("overrun second resp", 16'h0000, {15'b0, resp});
        wait_idle();
        model_line = {model_line[47:0], 16'h1234};
        ahb_read(ADDR_RESULT, HALF, rd, resp);
        post_result("overrun result", fir_ref(model_line, model_coef, resp), rd);
        ahb_read(ADDR_STATUS, HALF, rd, resp);
        post_result("overrun status", 16'h0100, rd);
        filter_sample(16'hf00d, 1'b1, "after overrun");

        polls = 0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
            polls++;
            if (polls > DRAIN_TIMEOUT) begin
                report_failure("timeout: pending result checks never completed");
            end
        end
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire
